/* qu_lite_params.svh */
/*
 * qu_lite core parameters
 * Data and instruction widths, register count, reorder-buffer depth
 * and the startup delay
 */

`ifndef QU_LITE_PARAMS_SVH
`define QU_LITE_PARAMS_SVH

`default_nettype none

`define QU_DATA_WIDTH 16
`define QU_INSTR_WIDTH 16
`define QU_ARCH_REGS 8
// Also sets the reservation-station size
`define QU_ROB_DEPTH 8
`define QU_STARTUP_CYCLES 3

`default_nettype wire

`endif

/* qu_lite_pkg.sv */
/*
 * qu_lite shared types
 * Opcodes, instruction layout, operand and reservation-station entries,
 * the retire broadcast and the commit record
 */

`include "qu_lite_params.svh"
`default_nettype none

package qu_lite_pkg;

    typedef logic [$clog2(`QU_ROB_DEPTH)-1:0] rob_addr_t;
    typedef logic [$clog2(`QU_ARCH_REGS)-1:0] reg_addr_t;
    typedef logic [`QU_DATA_WIDTH-1:0]        data_t;
    typedef logic [4:0]                       imm_t;      // Zero-extended on use

    typedef enum logic [1:0] {
        ADD  = 2'd0,
        SUB  = 2'd1,
        XOR  = 2'd2,
        ADDI = 2'd3
    } qu_op_e;

    // Instruction word, MSB first
    typedef struct packed {
        qu_op_e    op;
        reg_addr_t rd;
        reg_addr_t rs1;
        reg_addr_t rs2;
        imm_t      imm;
    } qu_instr_t;

    typedef struct packed {
        logic      ready;
        rob_addr_t tag;                                   // Producer slot while not ready
        data_t     value;
    } src_t;

    typedef struct packed {
        logic      valid;
        qu_op_e    op;
        reg_addr_t rd;
        src_t      src1;
        src_t      src2;
        imm_t      imm;
    } res_st_cell_t;

    typedef struct packed {
        rob_addr_t tag;
        reg_addr_t rd;
        data_t     value;
    } retire_t;

    typedef struct packed {
        reg_addr_t rd;
        data_t     value;
    } commit_t;

endpackage

`default_nettype wire

/* startup_ctrl.sv */
/*
 * Startup controller
 * Keeps the front end disabled for a fixed number of cycles after reset
 */

`include "qu_lite_params.svh"
`timescale 1ns/100ps
`default_nettype none

module startup_ctrl (
    input  logic clk,
    input  logic arst_n,
    output logic if_en,
    output logic core_ready
);

    localparam int unsigned CNT_W = $clog2(`QU_STARTUP_CYCLES + 1);

    logic [CNT_W-1:0] cnt;
    logic             en_q;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            cnt  <= '0;
            en_q <= 1'b0;
        end else if (!en_q) begin                         // Stops once released
            cnt <= cnt + 1'b1;
            if (cnt == CNT_W'(`QU_STARTUP_CYCLES - 1)) begin
                en_q <= 1'b1;
            end
        end
    end

    assign if_en      = en_q;
    assign core_ready = en_q;

endmodule

`default_nettype wire

/* front_end.sv */
/*
 * Front end
 * Decodes the incoming instruction, reads its operands and renames them
 * through the busy and tag tables, then dispatches into the reservation
 * station at the reorder-buffer tail
 */

`include "qu_lite_params.svh"
`timescale 1ns/100ps
`default_nettype none

module front_end
    import qu_lite_pkg::*;
(
    input  logic                       clk,
    input  logic                       arst_n,
    input  logic                       if_en,
    input  logic                       instr_valid,
    input  logic [`QU_INSTR_WIDTH-1:0] instr,
    input  rob_addr_t                  rob_tail,
    input  logic                       retire_en,
    input  retire_t                    retire,
    output reg_addr_t                  rf_rs1_addr,
    output reg_addr_t                  rf_rs2_addr,
    input  data_t                      rf_rs1_data,
    input  data_t                      rf_rs2_data,
    output logic                       res_st_wr_en,
    output rob_addr_t                  res_st_wr_addr,
    output res_st_cell_t               res_st_wr_cell,
    output logic                       rob_incr_tail
);

    logic [`QU_ARCH_REGS-1:0] busy;
    rob_addr_t                tag_tbl [`QU_ARCH_REGS];
    qu_instr_t                dec;
    logic                     dispatch;

    // Operand from the register file, the broadcast or still pending
    function automatic src_t rename_src(input reg_addr_t r, input data_t rf_val);
        src_t s;
        s.ready = 1'b1;
        s.tag   = '0;
        s.value = rf_val;
        if (r != '0 && busy[r]) begin
            s.tag = tag_tbl[r];
            if (retire_en && retire.tag == tag_tbl[r]) begin
                s.value = retire.value;                   // Same-cycle forward
            end else begin
                s.ready = 1'b0;
                s.value = '0;
            end
        end
        return s;
    endfunction

    assign dec      = qu_instr_t'(instr);
    assign dispatch = if_en & instr_valid;

    assign rf_rs1_addr = dec.rs1;
    assign rf_rs2_addr = dec.rs2;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Dispatch
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_comb begin
        res_st_wr_cell.valid = 1'b1;
        res_st_wr_cell.op    = dec.op;
        res_st_wr_cell.rd    = dec.rd;
        res_st_wr_cell.imm   = dec.imm;
        res_st_wr_cell.src1  = rename_src(dec.rs1, rf_rs1_data);
        if (dec.op == ADDI) begin
            res_st_wr_cell.src2 = '{ready: 1'b1, tag: '0, value: data_t'(dec.imm)};
        end else begin
            res_st_wr_cell.src2 = rename_src(dec.rs2, rf_rs2_data);
        end
    end

    assign res_st_wr_en   = dispatch;
    assign res_st_wr_addr = rob_tail;
    assign rob_incr_tail  = dispatch;

    // Busy table; a new producer of the same register beats the clear
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            busy <= '0;
        end else begin
            if (retire_en && retire.rd != '0 && tag_tbl[retire.rd] == retire.tag) begin
                busy[retire.rd] <= 1'b0;
            end
            if (dispatch && dec.rd != '0) begin
                busy[dec.rd] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (dispatch && dec.rd != '0) begin
            tag_tbl[dec.rd] <= rob_tail;
        end
    end

endmodule

`default_nettype wire

/* res_st.sv */
/*
 * Reservation station
 * One entry per reorder-buffer slot, woken by the retire broadcast,
 * with a combinational read port for the head entry
 */

`include "qu_lite_params.svh"
`timescale 1ns/100ps
`default_nettype none

module res_st
    import qu_lite_pkg::*;
(
    input  logic         clk,
    input  logic         arst_n,
    input  logic         wr_en,
    input  rob_addr_t    wr_addr,
    input  res_st_cell_t wr_cell,
    input  rob_addr_t    head_addr,
    output res_st_cell_t head_cell,
    input  logic         retire_en,
    input  retire_t      retire
);

    logic [`QU_ROB_DEPTH-1:0] vld;
    res_st_cell_t             cells [`QU_ROB_DEPTH];

    // Marks a waiting source ready when its producer retires
    function automatic src_t wake(input src_t s, input retire_t r);
        src_t w;
        w = s;
        if (!s.ready && s.tag == r.tag) begin
            w.ready = 1'b1;
            w.value = r.value;
        end
        return w;
    endfunction

    // A freed slot may be refilled in the cycle its broadcast goes out
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            vld <= '0;
        end else begin
            if (retire_en) begin
                vld[retire.tag] <= 1'b0;
            end
            if (wr_en) begin
                vld[wr_addr] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < `QU_ROB_DEPTH; i++) begin
            if (wr_en && wr_addr == rob_addr_t'(i)) begin
                cells[i] <= wr_cell;
            end else if (retire_en && vld[i]) begin
                cells[i].src1 <= wake(cells[i].src1, retire);
                cells[i].src2 <= wake(cells[i].src2, retire);
            end
        end
    end

    always_comb begin
        head_cell       = cells[head_addr];
        head_cell.valid = vld[head_addr];
    end

endmodule

`default_nettype wire

/* rf.sv */
/*
 * Register file
 * Two combinational read ports and one write port fed by the retire
 * broadcast; register 0 reads as zero
 */

`include "qu_lite_params.svh"
`timescale 1ns/100ps
`default_nettype none

module rf
    import qu_lite_pkg::*;
(
    input  logic      clk,
    input  logic      arst_n,
    input  reg_addr_t rs1_addr,
    input  reg_addr_t rs2_addr,
    output data_t     rs1_data,
    output data_t     rs2_data,
    input  logic      wr_en,
    input  retire_t   wr
);

    data_t regs [`QU_ARCH_REGS];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < `QU_ARCH_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en && wr.rd != '0) begin      // r0 writes dropped
            regs[wr.rd] <= wr.value;
        end
    end

    assign rs1_data = (rs1_addr == '0) ? '0 : regs[rs1_addr];
    assign rs2_data = (rs2_addr == '0) ? '0 : regs[rs2_addr];

endmodule

`default_nettype wire

/* back_end.sv */
/*
 * Back end
 * Reorder-buffer pointers and occupancy, in-order execution of the head
 * entry, and the registered retire broadcast and commit output
 */

`include "qu_lite_params.svh"
`timescale 1ns/100ps
`default_nettype none

module back_end
    import qu_lite_pkg::*;
(
    input  logic         clk,
    input  logic         arst_n,
    input  logic         schedule_en,
    output rob_addr_t    head_addr,
    input  res_st_cell_t head_cell,
    output logic         retire_en,
    output retire_t      retire,
    output rob_addr_t    rob_tail,
    input  logic         rob_incr_tail,
    output logic         rob_full,
    output logic         commit_valid,
    output commit_t      commit
);

    localparam int unsigned CNT_W = $clog2(`QU_ROB_DEPTH + 1);

    rob_addr_t        head_q;
    rob_addr_t        tail_q;
    logic [CNT_W-1:0] count_q;
    logic             fire;
    data_t            op_a;
    data_t            op_b;
    data_t            result;

    assign head_addr = head_q;
    assign rob_tail  = tail_q;
    assign rob_full  = (count_q == CNT_W'(`QU_ROB_DEPTH));

    assign fire = schedule_en & head_cell.valid & head_cell.src1.ready & head_cell.src2.ready;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // ALU, 16-bit wrapping
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_comb begin
        op_a = head_cell.src1.value;
        op_b = head_cell.src2.value;
        case (head_cell.op)
            ADD:     result = op_a + op_b;
            SUB:     result = op_a - op_b;
            XOR:     result = op_a ^ op_b;
            ADDI:    result = op_a + data_t'(head_cell.imm);
            default: result = '0;
        endcase
        if (head_cell.rd == '0) begin
            result = '0;                                  // r0 always commits zero
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            head_q       <= '0;
            tail_q       <= '0;
            count_q      <= '0;
            retire_en    <= 1'b0;
            commit_valid <= 1'b0;
        end else begin
            retire_en    <= fire;
            commit_valid <= fire;
            if (fire) begin
                head_q <= head_q + 1'b1;
            end
            if (rob_incr_tail) begin
                tail_q <= tail_q + 1'b1;
            end
            count_q <= count_q + CNT_W'(rob_incr_tail) - CNT_W'(fire);
        end
    end

    always_ff @(posedge clk) begin
        if (fire) begin
            retire <= '{tag: head_q, rd: head_cell.rd, value: result};
            commit <= '{rd: head_cell.rd, value: result};
        end
    end

endmodule

`default_nettype wire

/* qu_core.sv */
/*
 * qu_lite core top level
 * Startup controller, front end, reservation station, register file
 * and back end wired together
 */

`include "qu_lite_params.svh"
`timescale 1ns/100ps
`default_nettype none

module qu_core
    import qu_lite_pkg::*;
(
    input  logic                       clk,
    input  logic                       arst_n,
    input  logic                       instr_valid,
    input  logic [`QU_INSTR_WIDTH-1:0] instr,
    input  logic                       schedule_en,
    output logic                       core_ready,
    output logic                       rob_full,
    output logic                       commit_valid,
    output commit_t                    commit
);

    logic         if_en;
    reg_addr_t    rf_rs1_addr;
    reg_addr_t    rf_rs2_addr;
    data_t        rf_rs1_data;
    data_t        rf_rs2_data;
    logic         res_st_wr_en;
    rob_addr_t    res_st_wr_addr;
    res_st_cell_t res_st_wr_cell;
    rob_addr_t    head_addr;
    res_st_cell_t head_cell;
    logic         retire_en;
    retire_t      retire;
    rob_addr_t    rob_tail;
    logic         rob_incr_tail;

    startup_ctrl qu_startup_ctrl (
        .clk(clk),
        .arst_n(arst_n),
        .if_en(if_en),
        .core_ready(core_ready)
    );

    front_end qu_front_end (
        .clk(clk),
        .arst_n(arst_n),
        .if_en(if_en),
        .instr_valid(instr_valid),
        .instr(instr),
        .rob_tail(rob_tail),
        .retire_en(retire_en),
        .retire(retire),
        .rf_rs1_addr(rf_rs1_addr),
        .rf_rs2_addr(rf_rs2_addr),
        .rf_rs1_data(rf_rs1_data),
        .rf_rs2_data(rf_rs2_data),
        .res_st_wr_en(res_st_wr_en),
        .res_st_wr_addr(res_st_wr_addr),
        .res_st_wr_cell(res_st_wr_cell),
        .rob_incr_tail(rob_incr_tail)
    );

    res_st qu_res_st (
        .clk(clk),
        .arst_n(arst_n),
        .wr_en(res_st_wr_en),
        .wr_addr(res_st_wr_addr),
        .wr_cell(res_st_wr_cell),
        .head_addr(head_addr),
        .head_cell(head_cell),
        .retire_en(retire_en),
        .retire(retire)
    );

    rf qu_phy_rf (
        .clk(clk),
        .arst_n(arst_n),
        .rs1_addr(rf_rs1_addr),
        .rs2_addr(rf_rs2_addr),
        .rs1_data(rf_rs1_data),
        .rs2_data(rf_rs2_data),
        .wr_en(retire_en),
        .wr(retire)
    );

    back_end qu_back_end (
        .clk(clk),
        .arst_n(arst_n),
        .schedule_en(schedule_en),
        .head_addr(head_addr),
        .head_cell(head_cell),
        .retire_en(retire_en),
        .retire(retire),
        .rob_tail(rob_tail),
        .rob_incr_tail(rob_incr_tail),
        .rob_full(rob_full),
        .commit_valid(commit_valid),
        .commit(commit)
    );

endmodule

`default_nettype wire

/* qu_core_props.sv */
/*
 * qu_core interface properties
 * Reset state of the commit port, the instruction strobe rule and
 * known commit values
 */

`include "qu_lite_params.svh"
`timescale 1ns/100ps
`default_nettype none

module qu_core_props
    import qu_lite_pkg::*;
(
    input logic    clk,
    input logic    arst_n,
    input logic    instr_valid,
    input logic    rob_full,
    input logic    commit_valid,
    input commit_t commit
);

    commit_low_in_reset: assert property (@(posedge clk) !arst_n |-> !commit_valid)
        else $error("commit_valid high while in reset");

    // Source may only strobe into a ROB with room
    no_instr_when_full: assert property (
        @(posedge clk) disable iff (!arst_n) instr_valid |-> !rob_full)
        else $error("instr_valid high while rob_full is high");

    commit_known: assert property (
        @(posedge clk) disable iff (!arst_n) commit_valid |-> !$isunknown(commit))
        else $error("commit carries unknown bits");

endmodule

`default_nettype wire

/* qu_core_checker.sv */
/*
 * Commit checker
 * Queues the expected commits and compares every commit of the core
 * against the head of the queue
 */

`include "qu_lite_params.svh"
`timescale 1ns/100ps
`default_nettype none

module qu_core_checker
    import qu_lite_pkg::*;
(
    input  logic    clk,
    input  logic    arst_n,
    input  logic    exp_valid,
    input  commit_t exp_commit,
    input  logic    commit_valid,
    input  commit_t commit,
    output int      mismatches,
    output int      unexpected,
    output int      commits,
    output int      pending
);

    commit_t exp_q [$];
    commit_t want;

    always @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            exp_q.delete();
            mismatches = 0;
            unexpected = 0;
            commits    = 0;
            pending    = 0;
        end else begin
            if (exp_valid) begin
                exp_q.push_back(exp_commit);
            end
            if (commit_valid) begin
                commits++;
                if (exp_q.size() == 0) begin
                    $display("unexpected commit at %0t with nothing outstanding: rd %0d value %h",
                             $time, commit.rd, commit.value);
                    unexpected++;
                end else begin
                    want = exp_q.pop_front();
                    if (commit !== want) begin                // rd and value together
                        $display("mismatch at %0t: expected rd %0d value %h, got rd %0d value %h",
                                 $time, want.rd, want.value, commit.rd, commit.value);
                        mismatches++;
                    end
                end
            end
            pending = exp_q.size();
        end
    end

endmodule

`default_nettype wire

/* tb_qu_core.sv */
/*
 * qu_core testbench
 * Directed and random instruction streams, checked against a sequential
 * reference model by the commit checker
 */

`include "qu_lite_params.svh"
`timescale 1ns/100ps
`default_nettype none

module tb_qu_core
    import qu_lite_pkg::*;
();

    localparam int N_INSTR = 7 + 10 + 4 + 8 + 300;

    logic                       clk;
    logic                       arst_n;
    logic                       instr_valid;
    logic [`QU_INSTR_WIDTH-1:0] instr;
    logic                       schedule_en;
    logic                       core_ready;
    logic                       rob_full;
    logic                       commit_valid;
    commit_t                    commit;
    logic                       exp_valid;
    commit_t                    exp_commit;
    int                         mismatches;
    int                         unexpected;
    int                         commits;
    int                         pending;
    data_t                      model_rf [`QU_ARCH_REGS];
    logic [31:0]                lcg_state;
    int                         in_flight;                // Upper bound on ROB occupancy
    int                         sent;
    int                         other_errors;
    logic                       rand_sched;
    int                         ready_wait;

    bind qu_core qu_core_props qu_core_props_inst (
        .clk(clk),
        .arst_n(arst_n),
        .instr_valid(instr_valid),
        .rob_full(rob_full),
        .commit_valid(commit_valid),
        .commit(commit)
    );

    qu_core qu_core_inst (
        .clk(clk),
        .arst_n(arst_n),
        .instr_valid(instr_valid),
        .instr(instr),
        .schedule_en(schedule_en),
        .core_ready(core_ready),
        .rob_full(rob_full),
        .commit_valid(commit_valid),
        .commit(commit)
    );

    qu_core_checker qu_core_checker_inst (
        .clk(clk),
        .arst_n(arst_n),
        .exp_valid(exp_valid),
        .exp_commit(exp_commit),
        .commit_valid(commit_valid),
        .commit(commit),
        .mismatches(mismatches),
        .unexpected(unexpected),
        .commits(commits),
        .pending(pending)
    );

    always #4 clk = ~clk;

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state;
    endfunction

    function automatic qu_instr_t encode(input qu_op_e op, input int rd, input int rs1,
                                         input int rs2, input int imm);
        qu_instr_t i;
        i.op  = op;
        i.rd  = reg_addr_t'(rd);
        i.rs1 = reg_addr_t'(rs1);
        i.rs2 = reg_addr_t'(rs2);
        i.imm = imm_t'(imm);
        return i;
    endfunction

    // Sequential reference model in program order
    function automatic commit_t ref_exec(input qu_instr_t ins);
        data_t a;
        data_t b;
        data_t res;
        a = model_rf[ins.rs1];
        b = model_rf[ins.rs2];
        case (ins.op)
            ADD:     res = a + b;
            SUB:     res = a - b;
            XOR:     res = a ^ b;
            default: res = a + {11'b0, ins.imm};
        endcase
        if (ins.rd == '0) begin
            res = '0;
        end else begin
            model_rf[ins.rd] = res;
        end
        return '{rd: ins.rd, value: res};
    endfunction

    task automatic tick();
        logic [31:0] r;
        @(posedge clk);
        if (instr_valid) in_flight++;
        if (commit_valid) in_flight--;
        instr_valid <= 1'b0;
        exp_valid   <= 1'b0;
        if (rand_sched) begin
            r = lcg_next();
            schedule_en <= (r[31:30] != 2'b00);          // Enabled about 3/4 of cycles
        end
    endtask

    task automatic send(input qu_instr_t ins);
        tick();
        while (!(core_ready && !rob_full && in_flight < `QU_ROB_DEPTH)) begin
            tick();
        end
        instr_valid <= 1'b1;
        instr       <= ins;
        exp_valid   <= 1'b1;
        exp_commit  <= ref_exec(ins);
        sent++;
    endtask

    task automatic drain();
        tick();
        while (in_flight != 0) begin
            tick();
        end
    endtask

    initial begin
        clk          = 1'b0;
        arst_n       = 1'b0;
        instr_valid  = 1'b0;
        instr        = '0;
        schedule_en  = 1'b1;
        exp_valid    = 1'b0;
        exp_commit   = '0;
        lcg_state    = 32'd87;
        in_flight    = 0;
        sent         = 0;
        other_errors = 0;
        rand_sched   = 1'b0;
        ready_wait   = 0;
        for (int i = 0; i < `QU_ARCH_REGS; i++) begin
            model_rf[i] = '0;
        end
        repeat (4) @(posedge clk);
        arst_n <= 1'b1;

        // Startup delay before the core accepts instructions
        @(posedge clk);
        while (!core_ready && ready_wait < 4 * `QU_STARTUP_CYCLES) begin
            ready_wait++;
            @(posedge clk);
        end
        if (ready_wait != `QU_STARTUP_CYCLES) begin
            $display("core_ready took %0d cycles after reset release to rise, expected %0d",
                     ready_wait, `QU_STARTUP_CYCLES);
            other_errors++;
        end

        // Independent immediates
        for (int r = 1; r < 8; r++) begin
            send(encode(ADDI, r, 0, 0, 3 * r + 1));
        end
        drain();

        // Back-to-back dependent chain
        send(encode(ADDI, 1, 0, 0, 31));
        send(encode(ADD, 2, 1, 1, 0));
        send(encode(SUB, 3, 1, 2, 0));                    // Wraps below zero
        send(encode(XOR, 4, 3, 2, 0));
        send(encode(ADD, 5, 4, 4, 0));
        send(encode(SUB, 6, 5, 3, 0));
        send(encode(XOR, 7, 6, 7, 0));
        send(encode(ADD, 1, 7, 3, 0));
        send(encode(SUB, 2, 2, 1, 0));
        send(encode(ADDI, 3, 2, 0, 17));
        drain();

        // r0 as destination and source
        send(encode(ADDI, 0, 1, 0, 9));
        send(encode(ADD, 0, 2, 3, 0));
        send(encode(ADD, 4, 0, 0, 0));
        send(encode(XOR, 5, 0, 5, 0));
        drain();

        // Fill the ROB with the back end stalled
        schedule_en <= 1'b0;
        for (int i = 0; i < 8; i++) begin
            send(encode(ADDI, (i % 7) + 1, (i % 7) + 1, 0, i + 3));
        end
        tick();
        tick();
        if (!rob_full) begin
            $display("rob_full did not rise with eight instructions held at %0t", $time);
            other_errors++;
        end
        schedule_en <= 1'b1;
        drain();

        // Random mix with random back-end stalls
        rand_sched = 1'b1;
        for (int n = 0; n < 300; n++) begin
            logic [31:0] r;
            qu_instr_t   ins;
            r       = lcg_next();
            ins.op  = qu_op_e'(r[17:16]);
            ins.rd  = r[20:18];
            ins.rs1 = r[23:21];
            ins.rs2 = r[26:24];
            ins.imm = r[31:27];
            send(ins);
        end
        drain();
        rand_sched = 1'b0;
        schedule_en <= 1'b1;
        tick();
        tick();

        if (pending != 0) begin
            $display("%0d expected commits never arrived", pending);
        end
        if (commits != sent) begin
            $display("%0d commits seen for %0d instructions sent", commits, sent);
            other_errors++;
        end
        $display("errors: %0d mismatch, %0d unexpected commit, %0d missing commit, %0d other",
                 mismatches, unexpected, pending, other_errors);
        if (mismatches + unexpected + pending + other_errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

    // Watchdog
    initial begin
        repeat (N_INSTR * 40 + 200) @(posedge clk);
        $display("timeout: the run did not finish within %0d cycles", N_INSTR * 40 + 200);
        $display("SOME TESTS FAILED");
        $finish;
    end

endmodule

`default_nettype wire

/* qu_lite.f */
+incdir+.
qu_lite_pkg.sv
startup_ctrl.sv
front_end.sv
res_st.sv
rf.sv
back_end.sv
qu_core.sv
qu_core_props.sv
qu_core_checker.sv
tb_qu_core.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Builds the qu_lite testbench with Verilator, runs it and scans the log

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --assert --timing --timescale 1ns/100ps \
    -f qu_lite.f --top-module tb_qu_core -Mdir "$BUILD_DIR" -o Vtb_qu_core
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

"./$BUILD_DIR/Vtb_qu_core" > "$LOG" 2>&1
sim_status=$?
cat "$LOG"
if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

if grep -q "SOME TESTS FAILED" "$LOG"; then
    echo "Failure reported in $LOG"
    exit 1
fi

exit 0
